/* verilog/tzfe_config.svh */
`ifndef TZFE_CONFIG_SVH
`define TZFE_CONFIG_SVH

// tile grid starts, same on both axes
`define TZFE_TILE_ORIGIN0 15
`define TZFE_TILE_ORIGIN1 130
`define TZFE_TILE_ORIGIN2 245
`define TZFE_TILE_ORIGIN3 360

// tile edge length, both borders excluded
`define TZFE_TILE_SIZE 100

// pixels right of this column belong to the sidebar
`define TZFE_SIDEBAR_X 480

// digit cells in the sidebar
`define TZFE_DIGIT_X0 528
`define TZFE_DIGIT_X1 545
`define TZFE_DIGIT_X2 562
`define TZFE_DIGIT_X3 579
`define TZFE_DIGIT_W 16
`define TZFE_DIGIT_H 22

// row tops for the current score and the ranked table
`define TZFE_SCORE_ROW_Y 110
`define TZFE_TABLE_ROW_Y0 200
`define TZFE_TABLE_ROW_Y1 230
`define TZFE_TABLE_ROW_Y2 260

`define TZFE_SEG_T 3
`define TZFE_TABLE_DEPTH 3

`endif

/* verilog/vgaPkg.sv */
package vgaPkg;

	typedef logic [9:0] coordT;
	typedef logic [3:0] chanT;

	// red in the top channel, blue in the bottom one
	typedef chanT [2:0] colourT;

	localparam colourT BLACK = 12'h000;
	localparam colourT MENU_COLOUR = 12'h248;
	localparam colourT OVER_COLOUR = 12'h733;
	localparam colourT WIN_COLOUR = 12'hEC3;

	// playfield behind the tiles
	localparam colourT BOARD_COLOUR = 12'hBAA;
	localparam colourT SIDEBAR_COLOUR = 12'hFEC;
	localparam colourT DIGIT_COLOUR = 12'h765;

endpackage

/* verilog/gamePkg.sv */
package gamePkg;

	typedef logic [11:0] tileT;
	// tile k sits at bits 12k up to 12k+11
	typedef logic [16*$bits(tileT)-1:0] boardT;
	typedef logic [16:0] scoreT;
	typedef logic [3:0] digitT;

	// index 0 empty, index k for 2**k, last entry for anything else
	localparam vgaPkg::colourT TILE_COLOURS [13] = '{
		12'hCBB,
		12'hEED,
		12'hEEC,
		12'hFB7,
		12'hF96,
		12'hF76,
		12'hF53,
		12'hEC7,
		12'hEC6,
		12'hEC5,
		12'hEC3,
		12'hEC2,
		12'h333
	};

endpackage

/* verilog/boardRenderer.sv */
`timescale 1ns/1ps
`include "tzfe_config.svh"

module boardRenderer (
	input vgaPkg::coordT drawX,
	input vgaPkg::coordT drawY,
	input gamePkg::boardT board,
	output logic tileHit,
	output vgaPkg::chanT tileRed,
	output vgaPkg::chanT tileGreen,
	output vgaPkg::chanT tileBlue
);
	import vgaPkg::*;
	import gamePkg::*;

	localparam coordT ORIGINS [4] = '{
		`TZFE_TILE_ORIGIN0,
		`TZFE_TILE_ORIGIN1,
		`TZFE_TILE_ORIGIN2,
		`TZFE_TILE_ORIGIN3
	};
	localparam logic [3:0] OTHER_IDX = 4'd12;

	logic colHit;
	logic rowHit;
	logic [1:0] col;
	logic [1:0] row;
	logic [3:0] tileIdx;
	tileT tileVal;
	logic [3:0] colourIdx;
	colourT tileColour;

	// column from X and row from Y, gaps leave the hit flag low
	always_comb begin
		colHit = 1'b0;
		rowHit = 1'b0;
		col = 2'd0;
		row = 2'd0;
		for (int i = 0; i < 4; i++) begin
			if (drawX > ORIGINS[i] && drawX < ORIGINS[i] + `TZFE_TILE_SIZE) begin
				colHit = 1'b1;
				col = 2'(i);
			end
			if (drawY > ORIGINS[i] && drawY < ORIGINS[i] + `TZFE_TILE_SIZE) begin
				rowHit = 1'b1;
				row = 2'(i);
			end
		end
	end

	// tiles are stored column by column
	assign tileIdx = {col, row};
	assign tileVal = board[tileIdx * $bits(tileT) +: $bits(tileT)];
	assign tileHit = colHit & rowHit;

	// exponent of the tile value picks the colour
	always_comb begin
		colourIdx = OTHER_IDX;
		if (tileVal == '0)
			colourIdx = 4'd0;
		for (int k = 1; k < 12; k++) begin
			if (tileVal == (tileT'(1) << k))
				colourIdx = 4'(k);
		end
	end

	assign tileColour = TILE_COLOURS[colourIdx];
	assign tileRed = tileColour[2];
	assign tileGreen = tileColour[1];
	assign tileBlue = tileColour[0];

endmodule

/* verilog/highScoreTable.sv */
`timescale 1ns/1ps
`include "tzfe_config.svh"

module highScoreTable (
	input logic vga_clk,
	input logic rst,
	input logic saveScore,
	input gamePkg::scoreT score,
	output gamePkg::scoreT entry0,
	output gamePkg::scoreT entry1,
	output gamePkg::scoreT entry2
);
	import gamePkg::*;

	localparam int DEPTH = `TZFE_TABLE_DEPTH;

	scoreT entries [DEPTH];
	logic isNew;
	logic [$clog2(DEPTH+1)-1:0] slot;

	// zero and repeated scores are never stored
	always_comb begin
		isNew = (score != '0);
		slot = DEPTH[$clog2(DEPTH+1)-1:0];
		for (int i = 0; i < DEPTH; i++) begin
			if (entries[i] == score)
				isNew = 1'b0;
		end
		// walk upward so the highest smaller entry wins
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (score > entries[i])
				slot = i[$clog2(DEPTH+1)-1:0];
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			entries <= '{default: '0};
		end else if (saveScore && isNew && slot < DEPTH) begin
			// shift everything below the slot, the last one falls off
			for (int i = 1; i < DEPTH; i++) begin
				if (i > slot)
					entries[i] <= entries[i-1];
			end
			entries[slot] <= score;
		end
	end

	assign entry0 = entries[0];
	assign entry1 = entries[1];
	assign entry2 = entries[2];

endmodule

/* verilog/scoreSidebar.sv */
`timescale 1ns/1ps
`include "tzfe_config.svh"

module scoreSidebar (
	input logic vga_clk,
	input logic rst,
	input logic saveScore,
	input vgaPkg::coordT drawX,
	input vgaPkg::coordT drawY,
	input gamePkg::scoreT score,
	output vgaPkg::chanT sideRed,
	output vgaPkg::chanT sideGreen,
	output vgaPkg::chanT sideBlue
);
	import vgaPkg::*;
	import gamePkg::*;

	// current score first, then the ranked entries
	localparam coordT ROW_TOPS [4] = '{
		`TZFE_SCORE_ROW_Y,
		`TZFE_TABLE_ROW_Y0,
		`TZFE_TABLE_ROW_Y1,
		`TZFE_TABLE_ROW_Y2
	};
	localparam coordT COL_STARTS [4] = '{
		`TZFE_DIGIT_X0,
		`TZFE_DIGIT_X1,
		`TZFE_DIGIT_X2,
		`TZFE_DIGIT_X3
	};
	localparam int GLYPH_W = `TZFE_DIGIT_W - 1;
	localparam int GLYPH_H = `TZFE_DIGIT_H - 1;
	localparam int MID_V = (GLYPH_H - `TZFE_SEG_T) / 2;

	scoreT entry0;
	scoreT entry1;
	scoreT entry2;
	scoreT rowValues [4];
	logic rowHit;
	logic colHit;
	logic [1:0] rowSel;
	logic [1:0] colSel;
	scoreT rowValue;
	scoreT rem;
	digitT digits [4];
	digitT digit;
	logic [6:0] segs;
	coordT u;
	coordT v;
	logic top;
	logic mid;
	logic bot;
	logic upper;
	logic lower;
	logic left;
	logic right;
	logic lit;

	highScoreTable table0 (
		.vga_clk(vga_clk),
		.rst(rst),
		.saveScore(saveScore),
		.score(score),
		.entry0(entry0),
		.entry1(entry1),
		.entry2(entry2)
	);

	assign rowValues = '{score, entry0, entry1, entry2};

	// which digit cell the pixel falls in, borders excluded
	always_comb begin
		rowHit = 1'b0;
		colHit = 1'b0;
		rowSel = 2'd0;
		colSel = 2'd0;
		for (int i = 0; i < 4; i++) begin
			if (drawY > ROW_TOPS[i] && drawY < ROW_TOPS[i] + `TZFE_DIGIT_H) begin
				rowHit = 1'b1;
				rowSel = 2'(i);
			end
			if (drawX > COL_STARTS[i] && drawX < COL_STARTS[i] + `TZFE_DIGIT_W) begin
				colHit = 1'b1;
				colSel = 2'(i);
			end
		end
	end

	// one decimal split for whichever row is being drawn
	assign rowValue = rowValues[rowSel];
	assign rem = rowValue % 17'd10000;
	assign digits[0] = digitT'(rem / 17'd1000);
	assign digits[1] = digitT'((rem / 17'd100) % 17'd10);
	assign digits[2] = digitT'((rem / 17'd10) % 17'd10);
	assign digits[3] = digitT'(rem % 17'd10);
	assign digit = digits[colSel];

	// segments in a b c d e f g order
	always_comb begin
		case (digit)
			4'd0: segs = 7'b1111110;
			4'd1: segs = 7'b0110000;
			4'd2: segs = 7'b1101101;
			4'd3: segs = 7'b1111001;
			4'd4: segs = 7'b0110011;
			4'd5: segs = 7'b1011011;
			4'd6: segs = 7'b1011111;
			4'd7: segs = 7'b1110000;
			4'd8: segs = 7'b1111111;
			4'd9: segs = 7'b1111011;
			default: segs = 7'b0000000;
		endcase
	end

	// glyph-local position
	assign u = drawX - COL_STARTS[colSel] - 10'd1;
	assign v = drawY - ROW_TOPS[rowSel] - 10'd1;

	assign top = v < `TZFE_SEG_T;
	assign mid = v >= MID_V && v < MID_V + `TZFE_SEG_T;
	assign bot = v >= GLYPH_H - `TZFE_SEG_T;
	assign upper = v < MID_V + `TZFE_SEG_T;
	assign lower = v >= MID_V;
	assign left = u < `TZFE_SEG_T;
	assign right = u >= GLYPH_W - `TZFE_SEG_T;

	assign lit = rowHit && colHit && (
		(segs[6] && top) ||
		(segs[5] && right && upper) ||
		(segs[4] && right && lower) ||
		(segs[3] && bot) ||
		(segs[2] && left && lower) ||
		(segs[1] && left && upper) ||
		(segs[0] && mid));

	assign {sideRed, sideGreen, sideBlue} = lit ? DIGIT_COLOUR : SIDEBAR_COLOUR;

endmodule

/* verilog/pixelMux.sv */
`timescale 1ns/1ps
`include "tzfe_config.svh"

module pixelMux (
	input logic vga_clk,
	input logic rst,
	input logic blank,
	input logic menu,
	input logic checkOver,
	input logic checkWin,
	input vgaPkg::coordT drawX,
	input logic tileHit,
	input vgaPkg::chanT tileRed,
	input vgaPkg::chanT tileGreen,
	input vgaPkg::chanT tileBlue,
	input vgaPkg::chanT sideRed,
	input vgaPkg::chanT sideGreen,
	input vgaPkg::chanT sideBlue,
	output vgaPkg::chanT red,
	output vgaPkg::chanT green,
	output vgaPkg::chanT blue
);
	import vgaPkg::*;

	// full-screen states override the board, blanking overrides all
	always_ff @(posedge vga_clk) begin
		if (rst)
			{red, green, blue} <= BLACK;
		else if (!blank)
			{red, green, blue} <= BLACK;
		else if (menu)
			{red, green, blue} <= MENU_COLOUR;
		else if (checkOver)
			{red, green, blue} <= OVER_COLOUR;
		else if (checkWin)
			{red, green, blue} <= WIN_COLOUR;
		else if (tileHit)
			{red, green, blue} <= {tileRed, tileGreen, tileBlue};
		else if (drawX > `TZFE_SIDEBAR_X)
			{red, green, blue} <= {sideRed, sideGreen, sideBlue};
		else
			{red, green, blue} <= BOARD_COLOUR;
	end

endmodule

/* verilog/tzfeDisplay.sv */
`timescale 1ns/1ps

module tzfeDisplay (
	input logic vga_clk,
	input logic rst,
	input logic start,
	input logic menu,
	input logic checkOver,
	input logic checkWin,
	input logic blank,
	input vgaPkg::coordT drawX,
	input vgaPkg::coordT drawY,
	input gamePkg::boardT board,
	input gamePkg::scoreT score,
	output vgaPkg::chanT red,
	output vgaPkg::chanT green,
	output vgaPkg::chanT blue
);
	import vgaPkg::*;

	logic saveScore;
	logic tileHit;
	chanT tileRed;
	chanT tileGreen;
	chanT tileBlue;
	chanT sideRed;
	chanT sideGreen;
	chanT sideBlue;

	// the table records while a game starts or ends
	assign saveScore = start | checkOver | checkWin;

	boardRenderer board0 (
		.drawX(drawX),
		.drawY(drawY),
		.board(board),
		.tileHit(tileHit),
		.tileRed(tileRed),
		.tileGreen(tileGreen),
		.tileBlue(tileBlue)
	);

	scoreSidebar sidebar0 (
		.vga_clk(vga_clk),
		.rst(rst),
		.saveScore(saveScore),
		.drawX(drawX),
		.drawY(drawY),
		.score(score),
		.sideRed(sideRed),
		.sideGreen(sideGreen),
		.sideBlue(sideBlue)
	);

	pixelMux mux0 (
		.vga_clk(vga_clk),
		.rst(rst),
		.blank(blank),
		.menu(menu),
		.checkOver(checkOver),
		.checkWin(checkWin),
		.drawX(drawX),
		.tileHit(tileHit),
		.tileRed(tileRed),
		.tileGreen(tileGreen),
		.tileBlue(tileBlue),
		.sideRed(sideRed),
		.sideGreen(sideGreen),
		.sideBlue(sideBlue),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* bench/tzfe_assertions.sv */
`timescale 1ns/1ps

module tableChecks (
	input logic vga_clk,
	input logic rst,
	input logic saveScore,
	input gamePkg::scoreT entry0,
	input gamePkg::scoreT entry1,
	input gamePkg::scoreT entry2
);
	int failCount = 0;

	// ranked highest first
	rankOrder: assert property (@(posedge vga_clk) disable iff (rst)
		entry0 >= entry1 && entry1 >= entry2)
		else begin
			failCount++;
			$error("high-score entries are out of order");
		end

	tableHold: assert property (@(posedge vga_clk) disable iff (rst)
		!saveScore |=> $stable({entry0, entry1, entry2}))
		else begin
			failCount++;
			$error("high-score table changed while no save was requested");
		end

	// a stored score shows up once
	distinctEntries: assert property (@(posedge vga_clk) disable iff (rst)
		(entry1 == '0 || entry1 != entry0)
		&& (entry2 == '0 || (entry2 != entry1 && entry2 != entry0)))
		else begin
			failCount++;
			$error("high-score table holds the same nonzero score twice");
		end

endmodule

bind highScoreTable tableChecks checks0 (
	.vga_clk(vga_clk),
	.rst(rst),
	.saveScore(saveScore),
	.entry0(entry0),
	.entry1(entry1),
	.entry2(entry2)
);

/* bench/tzfeDisplayTb.sv */
`timescale 1ns/1ps
`include "tzfe_config.svh"

module tzfeDisplayTb;
	import vgaPkg::*;
	import gamePkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int BLANK_PIXELS = 100;
	localparam int SCREEN_PIXELS = 400;
	localparam int BOARD_COUNT = 16;
	localparam int BOARD_PIXELS = 120;
	localparam int SCORE_COUNT = 2;
	localparam int SIDE_PIXELS = 200;
	localparam int SAVE_COUNT = 60;
	localparam int ROW_W = `TZFE_DIGIT_X3 + `TZFE_DIGIT_W - `TZFE_DIGIT_X0 + 1;
	localparam int ROW_PIXELS = (`TZFE_DIGIT_H + 1) * ROW_W;
	// every test also spends one cycle draining the output register
	localparam int STIM_CYCLES = RESET_CYCLES + 1 + BLANK_PIXELS + SCREEN_PIXELS
		+ BOARD_COUNT * BOARD_PIXELS + SCORE_COUNT * ROW_PIXELS + SIDE_PIXELS
		+ SAVE_COUNT + 3 * ROW_PIXELS + 5;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

	localparam int TILE_ORIGINS [4] = '{`TZFE_TILE_ORIGIN0, `TZFE_TILE_ORIGIN1,
		`TZFE_TILE_ORIGIN2, `TZFE_TILE_ORIGIN3};
	localparam int ROW_TOPS [4] = '{`TZFE_SCORE_ROW_Y, `TZFE_TABLE_ROW_Y0,
		`TZFE_TABLE_ROW_Y1, `TZFE_TABLE_ROW_Y2};
	localparam int COL_STARTS [4] = '{`TZFE_DIGIT_X0, `TZFE_DIGIT_X1,
		`TZFE_DIGIT_X2, `TZFE_DIGIT_X3};

	logic vga_clk;
	logic rst;
	logic start;
	logic menu;
	logic checkOver;
	logic checkWin;
	logic blank;
	coordT drawX;
	coordT drawY;
	boardT board;
	scoreT score;
	chanT red;
	chanT green;
	chanT blue;

	int unsigned rngState = 83638;
	scoreT modelTable [3];
	colourT expColour;
	logic expValid = 1'b0;
	int testNum = 0;
	int testChecks = 0;
	int testErrors = 0;
	int totalChecks = 0;
	int totalErrors = 0;
	int cycles = 0;

	tzfeDisplay dut (.*);

	initial begin
		vga_clk = 1'b0;
		forever #50 vga_clk = ~vga_clk;
	end

	function automatic int unsigned nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState >> 8;
	endfunction

	function automatic int randBelow(input int n);
		return int'(nextRand() % n);
	endfunction

	// mostly legal powers of two, some empty, some junk
	function automatic boardT randomBoard();
		boardT b;
		int r;
		for (int k = 0; k < 16; k++) begin
			r = randBelow(16);
			if (r <= 11)
				b[k*12 +: 12] = (r == 0) ? 12'd0 : 12'(2 ** r);
			else
				b[k*12 +: 12] = 12'(randBelow(4096));
		end
		return b;
	endfunction

	function automatic int tileSpan(input coordT p);
		int idx;
		idx = -1;
		for (int i = 0; i < 4; i++) begin
			if (p > TILE_ORIGINS[i] && p < TILE_ORIGINS[i] + `TZFE_TILE_SIZE)
				idx = i;
		end
		return idx;
	endfunction

	function automatic colourT tileColourOf(input tileT val);
		colourT c;
		c = (val == 0) ? TILE_COLOURS[0] : TILE_COLOURS[12];
		for (int k = 1; k <= 11; k++) begin
			if (val == 2 ** k)
				c = TILE_COLOURS[k];
		end
		return c;
	endfunction

	// bit 0 is segment a, bit 6 is segment g
	function automatic logic segmentLit(input int d, input int u, input int v);
		logic [6:0] on;
		case (d)
			0: on = 7'b0111111;
			1: on = 7'b0000110;
			2: on = 7'b1011011;
			3: on = 7'b1001111;
			4: on = 7'b1100110;
			5: on = 7'b1101101;
			6: on = 7'b1111101;
			7: on = 7'b0000111;
			8: on = 7'b1111111;
			default: on = 7'b1101111;
		endcase
		return (on[0] && v <= 2) || (on[1] && u >= 12 && v <= 11)
			|| (on[2] && u >= 12 && v >= 9) || (on[3] && v >= 18)
			|| (on[4] && u <= 2 && v >= 9) || (on[5] && u <= 2 && v <= 11)
			|| (on[6] && v >= 9 && v <= 11);
	endfunction

	function automatic colourT sidebarColour(input coordT x, input coordT y, input scoreT cur);
		colourT c;
		int value;
		int d;
		c = SIDEBAR_COLOUR;
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < 4; i++) begin
				if (y > ROW_TOPS[r] && y < ROW_TOPS[r] + `TZFE_DIGIT_H
						&& x > COL_STARTS[i] && x < COL_STARTS[i] + `TZFE_DIGIT_W) begin
					value = int'((r == 0) ? cur : modelTable[r-1]) % 10000;
					d = (value / 10 ** (3 - i)) % 10;
					if (segmentLit(d, x - COL_STARTS[i] - 1, y - ROW_TOPS[r] - 1))
						c = DIGIT_COLOUR;
				end
			end
		end
		return c;
	endfunction

	function automatic colourT expectedPixel(input coordT x, input coordT y, input logic bl,
			input logic mn, input logic ov, input logic wn, input boardT brd, input scoreT sc);
		int col;
		int row;
		col = tileSpan(x);
		row = tileSpan(y);
		if (!bl)
			return BLACK;
		if (mn)
			return MENU_COLOUR;
		if (ov)
			return OVER_COLOUR;
		if (wn)
			return WIN_COLOUR;
		if (col >= 0 && row >= 0)
			return tileColourOf(brd[(4 * col + row) * 12 +: 12]);
		if (x > `TZFE_SIDEBAR_X)
			return sidebarColour(x, y, sc);
		return BOARD_COLOUR;
	endfunction

	// new score goes in front of the first smaller entry
	function automatic void insertScore(input scoreT sc);
		int pos;
		pos = 3;
		for (int i = 0; i < 3; i++) begin
			if (modelTable[i] == sc)
				return;
		end
		for (int i = 0; i < 3; i++) begin
			if (pos == 3 && modelTable[i] < sc)
				pos = i;
		end
		if (sc == 0 || pos == 3)
			return;
		for (int i = 2; i > pos; i--)
			modelTable[i] = modelTable[i-1];
		modelTable[pos] = sc;
	endfunction

	task automatic checkColour(input colourT exp);
		testChecks++;
		assert ({red, green, blue} == exp) else begin
			$display("Error at %0t ns: red/green/blue is %h, expected %h",
				$time, {red, green, blue}, exp);
			testErrors++;
		end
	endtask

	// output of the previous pixel is checked while this one is in flight
	task automatic applyInputs(input coordT x, input coordT y, input logic bl, input logic mn,
			input logic ov, input logic wn, input logic st, input boardT brd, input scoreT sc);
		@(posedge vga_clk);
		drawX <= x;
		drawY <= y;
		blank <= bl;
		menu <= mn;
		checkOver <= ov;
		checkWin <= wn;
		start <= st;
		board <= brd;
		score <= sc;
		@(negedge vga_clk);
		if (expValid)
			checkColour(expColour);
		expColour = expectedPixel(x, y, bl, mn, ov, wn, brd, sc);
		expValid = 1'b1;
		if (st || ov || wn)
			insertScore(sc);
	endtask

	task automatic finishTest(input string name);
		@(posedge vga_clk);
		@(negedge vga_clk);
		if (expValid)
			checkColour(expColour);
		expValid = 1'b0;
		testNum++;
		$display("test %0d (%s): %0d checks, %0d errors", testNum, name, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic scanRow(input int top, input boardT brd, input scoreT sc);
		for (int y = top; y <= top + `TZFE_DIGIT_H; y++) begin
			for (int x = `TZFE_DIGIT_X0; x < `TZFE_DIGIT_X0 + ROW_W; x++)
				applyInputs(coordT'(x), coordT'(y), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, brd, sc);
		end
	endtask

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge vga_clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Something failed");
		$finish;
	end

	initial begin
		boardT brd;
		scoreT s;
		int sel;
		int assertFails;
		rst = 1'b1;
		start = 1'b0;
		// a visible menu pixel, only the reset keeps the output black
		menu = 1'b1;
		checkOver = 1'b0;
		checkWin = 1'b0;
		blank = 1'b1;
		drawX = '0;
		drawY = '0;
		board = '0;
		score = '0;
		modelTable = '{default: '0};
		s = '0;

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge vga_clk);
			if (i == RESET_CYCLES - 1) begin
				rst <= 1'b0;
				blank <= 1'b0;
				menu <= 1'b0;
			end
			@(negedge vga_clk);
			checkColour(BLACK);
		end
		@(posedge vga_clk);
		@(negedge vga_clk);
		checkColour(BLACK);
		repeat (BLANK_PIXELS)
			applyInputs(coordT'(randBelow(640)), coordT'(randBelow(480)), 1'b0, randBelow(2),
				randBelow(2), randBelow(2), randBelow(2), randomBoard(), scoreT'(randBelow(1 << 17)));
		finishTest("reset and blanking");

		repeat (SCREEN_PIXELS)
			applyInputs(coordT'(randBelow(640)), coordT'(randBelow(480)), 1'b1, randBelow(2),
				randBelow(2), randBelow(2), 1'b0, randomBoard(), scoreT'(randBelow(1 << 17)));
		finishTest("screen priority");

		repeat (BOARD_COUNT) begin
			brd = randomBoard();
			repeat (BOARD_PIXELS)
				applyInputs(coordT'(randBelow(480)), coordT'(randBelow(480)), 1'b1, 1'b0,
					1'b0, 1'b0, 1'b0, brd, '0);
		end
		finishTest("tiles");

		repeat (SCORE_COUNT)
			scanRow(`TZFE_SCORE_ROW_Y, brd, scoreT'(randBelow(1 << 17)));
		repeat (SIDE_PIXELS)
			applyInputs(coordT'(481 + randBelow(159)), coordT'(randBelow(480)), 1'b1, 1'b0,
				1'b0, 1'b0, 1'b0, brd, scoreT'(randBelow(1 << 17)));
		finishTest("score digits");

		// repeats and tiny values must leave the table alone
		repeat (SAVE_COUNT) begin
			case (randBelow(4))
				0: s = s;
				1: s = scoreT'(randBelow(16));
				default: s = scoreT'(randBelow(1 << 17));
			endcase
			sel = randBelow(4);
			applyInputs(coordT'(randBelow(640)), coordT'(randBelow(480)), 1'b1, 1'b0,
				sel == 2, sel == 3, sel == 1, brd, s);
		end
		scanRow(`TZFE_TABLE_ROW_Y0, brd, '0);
		scanRow(`TZFE_TABLE_ROW_Y1, brd, '0);
		scanRow(`TZFE_TABLE_ROW_Y2, brd, '0);
		finishTest("high scores");

		assertFails = dut.sidebar0.table0.checks0.failCount;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			testNum, totalChecks, totalErrors, assertFails);
		if (totalErrors == 0 && assertFails == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+verilog
verilog/vgaPkg.sv
verilog/gamePkg.sv
verilog/boardRenderer.sv
verilog/highScoreTable.sv
verilog/scoreSidebar.sv
verilog/pixelMux.sv
verilog/tzfeDisplay.sv
bench/tzfe_assertions.sv
bench/tzfeDisplayTb.sv

/* Bender.yml */
package:
  name: tzfe_display

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vgaPkg.sv
      - verilog/gamePkg.sv
      - verilog/boardRenderer.sv
      - verilog/highScoreTable.sv
      - verilog/scoreSidebar.sv
      - verilog/pixelMux.sv
      - verilog/tzfeDisplay.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tzfe_assertions.sv
      - bench/tzfeDisplayTb.sv
